/* design/immu_pkg.sv */
package immu_pkg;

    // Sv32 address widths
    typedef logic [31:0] vaddr_t;
    // Physical and memory address
    typedef logic [33:0] paddr_t;

    // Virtual page number, vpn1 in the upper half
    typedef logic [19:0] vpn_t;
    // One 10-bit half of a VPN
    typedef logic [9:0]  vpn_half_t;

    // Physical page number and its two fields
    typedef logic [21:0] ppn_t;
    typedef logic [11:0] ppn1_t;
    typedef logic [9:0]  ppn0_t;

    // Page table entry
    typedef logic [31:0] pte_t;

    // PTE flag bits
    localparam int unsigned PTE_V = 0;
    localparam int unsigned PTE_R = 1;
    localparam int unsigned PTE_W = 2;
    localparam int unsigned PTE_X = 3;

    // PPN field starts here in a PTE
    localparam int unsigned PTE_PPN_LSB = 10;

    // Byte offset inside a 4 KiB page
    localparam int unsigned PAGE_OFFSET_W = 12;

    // Walker FSM
    typedef enum logic [2:0] {
        WALK_IDLE,
        WALK_READ_L1,
        WALK_WAIT_L1,
        WALK_READ_L0,
        WALK_WAIT_L0,
        WALK_DONE
    } walk_state_e;

    // Controller FSM
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_RESPOND,
        CTRL_WALK
    } ctrl_state_e;

endpackage

/* design/itlb.sv */
`timescale 1ns/1ns

module itlb
    import immu_pkg::*;
#(
    parameter int unsigned TLB_ENTRIES = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    // Lookup port answered in the same cycle
    input  logic lookup_valid,
    input  vpn_t lookup_vpn,
    output logic hit,
    output pte_t hit_pte,
    output logic hit_mega,
    // Refill port written at the next edge
    input  logic refill_valid,
    input  vpn_t refill_vpn,
    input  pte_t refill_pte,
    input  logic refill_mega
);

    localparam int unsigned IDX_W = $clog2(TLB_ENTRIES);

    // Entry storage
    logic      valid_q [TLB_ENTRIES];
    vpn_half_t vpn1_q  [TLB_ENTRIES];
    vpn_half_t vpn0_q  [TLB_ENTRIES];
    pte_t      pte_q   [TLB_ENTRIES];
    logic      mega_q  [TLB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    vpn_half_t        lk_vpn1;
    vpn_half_t        lk_vpn0;
    logic             tag_match;

    // Index from low bits of vpn1 so a megapage and its 4 KiB neighbours collide
    assign rd_idx  = lookup_vpn[10 +: IDX_W];
    assign wr_idx  = refill_vpn[10 +: IDX_W];
    assign lk_vpn1 = lookup_vpn[19:10];
    assign lk_vpn0 = lookup_vpn[9:0];

    // Megapage ignores vpn0
    assign tag_match = (vpn1_q[rd_idx] == lk_vpn1) &&
                       ((vpn0_q[rd_idx] == lk_vpn0) || mega_q[rd_idx]);

    assign hit      = lookup_valid && valid_q[rd_idx] && tag_match;
    assign hit_pte  = pte_q[rd_idx];
    assign hit_mega = mega_q[rd_idx];

    // Valid bits with flush taking priority over refill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (flush) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (refill_valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (refill_valid && !flush) begin
            vpn1_q[wr_idx] <= refill_vpn[19:10];
            vpn0_q[wr_idx] <= refill_vpn[9:0];
            pte_q[wr_idx]  <= refill_pte;
            mega_q[wr_idx] <= refill_mega;
        end
    end

    // Size must be a power of two in range
    initial begin
        assert (TLB_ENTRIES >= 2 && TLB_ENTRIES <= 1024 &&
                (TLB_ENTRIES & (TLB_ENTRIES - 1)) == 0)
            else $error("itlb: TLB_ENTRIES must be a power of two from 2 to 1024");
    end

    // No answer without a lookup
    a_hit_needs_lookup: assert property (
        @(posedge clk) disable iff (!rst_n)
        hit |-> lookup_valid
    );

endmodule

/* design/page_walker.sv */
`timescale 1ns/1ns

module page_walker
    import immu_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  ppn_t   satp_ppn,
    // Walk request from the controller
    input  logic   walk_start,
    input  vpn_t   walk_vpn,
    // Memory read port
    output logic   mem_req,
    output paddr_t mem_addr,
    input  logic   mem_valid,
    input  pte_t   mem_rdata,
    // Walk result
    output logic   walk_done,
    output pte_t   walk_pte,
    output logic   walk_mega,
    output logic   walk_fault
);

    walk_state_e state_q;
    vpn_t        vpn_q;
    pte_t        pte_q;
    logic        mega_q;
    logic        fault_q;

    ppn_t        next_ppn;
    vpn_half_t   vpn1;
    vpn_half_t   vpn0;

    // Well formed entry: valid and not write-only
    function automatic logic pte_ok(pte_t pte);
        return pte[PTE_V] && !(!pte[PTE_R] && pte[PTE_W]);
    endfunction

    // Leaf when readable or executable
    function automatic logic pte_leaf(pte_t pte);
        return pte[PTE_R] || pte[PTE_X];
    endfunction

    // Megapage needs ppn0 zero
    function automatic logic pte_misaligned(pte_t pte);
        ppn_t ppn;
        ppn = pte[31:PTE_PPN_LSB];
        return ppn[9:0] != '0;
    endfunction

    assign vpn1 = vpn_q[19:10];
    assign vpn0 = vpn_q[9:0];

    // Level-0 table comes from the stored level-1 pointer
    assign next_ppn = pte_q[31:PTE_PPN_LSB];

    // Read strobes are single-cycle states
    assign mem_req = (state_q == WALK_READ_L1) || (state_q == WALK_READ_L0);

    // Level-1 from satp, level-0 from pointer
    always_comb begin
        if (state_q == WALK_READ_L0) begin
            mem_addr = {next_ppn, vpn0, 2'b00};
        end else begin
            mem_addr = {satp_ppn, vpn1, 2'b00};
        end
    end

    assign walk_done  = (state_q == WALK_DONE);
    assign walk_pte   = pte_q;
    assign walk_mega  = mega_q;
    assign walk_fault = fault_q;

    // Walk FSM and result flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= WALK_IDLE;
            mega_q  <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            case (state_q)
                WALK_IDLE: begin
                    if (walk_start) begin
                        mega_q  <= 1'b0;
                        fault_q <= 1'b0;
                        state_q <= WALK_READ_L1;
                    end
                end
                WALK_READ_L1: state_q <= WALK_WAIT_L1;
                WALK_WAIT_L1: begin
                    if (mem_valid) begin
                        if (!pte_ok(mem_rdata)) begin
                            fault_q <= 1'b1;
                            state_q <= WALK_DONE;
                        end else if (pte_leaf(mem_rdata)) begin
                            // Megapage leaf, execute and alignment checks
                            mega_q  <= 1'b1;
                            fault_q <= !mem_rdata[PTE_X] || pte_misaligned(mem_rdata);
                            state_q <= WALK_DONE;
                        end else begin
                            // Pointer to level-0 table
                            state_q <= WALK_READ_L0;
                        end
                    end
                end
                WALK_READ_L0: state_q <= WALK_WAIT_L0;
                WALK_WAIT_L0: begin
                    if (mem_valid) begin
                        // Must be a leaf with X, non-leaf faults here
                        fault_q <= !pte_ok(mem_rdata) || !mem_rdata[PTE_X];
                        state_q <= WALK_DONE;
                    end
                end
                WALK_DONE: state_q <= WALK_IDLE;
                default:   state_q <= WALK_IDLE;
            endcase
        end
    end

    // Request VPN and fetched entry
    always_ff @(posedge clk) begin
        if (state_q == WALK_IDLE && walk_start) begin
            vpn_q <= walk_vpn;
        end
        if (mem_valid) begin
            pte_q <= mem_rdata;
        end
    end

    // Memory answers only an outstanding read
    a_rdata_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_valid |-> (state_q == WALK_WAIT_L1 || state_q == WALK_WAIT_L0)
    );

    // Controller never starts a second walk
    a_start_in_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        walk_start |-> state_q == WALK_IDLE
    );

endmodule

/* design/immu_ctrl.sv */
`timescale 1ns/1ns

module immu_ctrl
    import immu_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    // Fetch side
    input  logic   fetch_req,
    input  vaddr_t fetch_vaddr,
    output logic   done,
    output paddr_t paddr,
    output logic   page_fault,
    // TLB lookup
    output logic   lookup_valid,
    output vpn_t   lookup_vpn,
    input  logic   hit,
    input  pte_t   hit_pte,
    input  logic   hit_mega,
    // TLB refill
    output logic   refill_valid,
    output vpn_t   refill_vpn,
    output pte_t   refill_pte,
    output logic   refill_mega,
    // Walker
    output logic   walk_start,
    output vpn_t   walk_vpn,
    input  logic   walk_done,
    input  pte_t   walk_pte,
    input  logic   walk_mega,
    input  logic   walk_fault
);

    ctrl_state_e state_q;
    vaddr_t      vaddr_q;
    paddr_t      paddr_q;
    pte_t        fill_pte_q;
    logic        fill_mega_q;
    logic        fill_q;
    logic        fault_q;

    // Physical address from leaf entry, megapage keeps vpn0
    function automatic paddr_t form_paddr(vaddr_t va, pte_t pte, logic mega);
        ppn_t      ppn;
        ppn1_t     ppn1;
        ppn0_t     ppn0;
        vpn_half_t va_vpn0;
        ppn     = pte[31:PTE_PPN_LSB];
        ppn1    = ppn[21:10];
        ppn0    = ppn[9:0];
        va_vpn0 = va[21:PAGE_OFFSET_W];
        return {ppn1, (mega ? va_vpn0 : ppn0), va[PAGE_OFFSET_W-1:0]};
    endfunction

    // Lookup in the request cycle
    assign lookup_valid = fetch_req && (state_q == CTRL_IDLE);
    assign lookup_vpn   = fetch_vaddr[31:PAGE_OFFSET_W];

    // Miss goes straight to the walker
    assign walk_start = lookup_valid && !hit;
    assign walk_vpn   = fetch_vaddr[31:PAGE_OFFSET_W];

    // Refill together with done
    assign refill_valid = (state_q == CTRL_RESPOND) && fill_q;
    assign refill_vpn   = vaddr_q[31:PAGE_OFFSET_W];
    assign refill_pte   = fill_pte_q;
    assign refill_mega  = fill_mega_q;

    assign done       = (state_q == CTRL_RESPOND);
    assign paddr      = paddr_q;
    assign page_fault = done && fault_q;

    // Controller FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= CTRL_IDLE;
            fill_q  <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            case (state_q)
                CTRL_IDLE: begin
                    if (fetch_req) begin
                        fill_q  <= 1'b0;
                        fault_q <= 1'b0;
                        state_q <= hit ? CTRL_RESPOND : CTRL_WALK;
                    end
                end
                CTRL_WALK: begin
                    if (walk_done) begin
                        // Faults stay out of the TLB
                        fill_q  <= !walk_fault;
                        fault_q <= walk_fault;
                        state_q <= CTRL_RESPOND;
                    end
                end
                CTRL_RESPOND: state_q <= CTRL_IDLE;
                default:      state_q <= CTRL_IDLE;
            endcase
        end
    end

    // Request address, result and refill payload
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            vaddr_q <= fetch_vaddr;
            paddr_q <= form_paddr(fetch_vaddr, hit_pte, hit_mega);
        end else if (state_q == CTRL_WALK && walk_done) begin
            paddr_q     <= form_paddr(vaddr_q, walk_pte, walk_mega);
            fill_pte_q  <= walk_pte;
            fill_mega_q <= walk_mega;
        end
    end

    // One translation at a time
    a_fetch_in_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch_req |-> state_q == CTRL_IDLE
    );

    // Walker answers only a walk this controller started
    a_walk_done_in_walk: assert property (
        @(posedge clk) disable iff (!rst_n)
        walk_done |-> state_q == CTRL_WALK
    );

endmodule

/* design/immu_top.sv */
`timescale 1ns/1ns

module immu_top
    import immu_pkg::*;
#(
    parameter int unsigned TLB_ENTRIES = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    // Root page table
    input  ppn_t   satp_ppn,
    // Fetch request and response
    input  logic   fetch_req,
    input  vaddr_t fetch_vaddr,
    input  logic   flush,
    output logic   done,
    output paddr_t paddr,
    output logic   page_fault,
    // Page table memory
    output logic   mem_req,
    output paddr_t mem_addr,
    input  logic   mem_valid,
    input  pte_t   mem_rdata
);

    // Controller to TLB
    logic lookup_valid;
    vpn_t lookup_vpn;
    logic hit;
    pte_t hit_pte;
    logic hit_mega;
    logic refill_valid;
    vpn_t refill_vpn;
    pte_t refill_pte;
    logic refill_mega;

    // Controller to walker
    logic walk_start;
    vpn_t walk_vpn;
    logic walk_done;
    pte_t walk_pte;
    logic walk_mega;
    logic walk_fault;

    immu_ctrl i_immu_ctrl (
        .clk, .rst_n, .fetch_req, .fetch_vaddr, .done, .paddr, .page_fault,
        .lookup_valid, .lookup_vpn, .hit, .hit_pte, .hit_mega,
        .refill_valid, .refill_vpn, .refill_pte, .refill_mega,
        .walk_start, .walk_vpn, .walk_done, .walk_pte, .walk_mega, .walk_fault
    );

    // Flush goes straight to the TLB
    itlb #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) i_itlb (
        .clk, .rst_n, .flush,
        .lookup_valid, .lookup_vpn, .hit, .hit_pte, .hit_mega,
        .refill_valid, .refill_vpn, .refill_pte, .refill_mega
    );

    page_walker i_page_walker (
        .clk, .rst_n, .satp_ppn, .walk_start, .walk_vpn,
        .mem_req, .mem_addr, .mem_valid, .mem_rdata,
        .walk_done, .walk_pte, .walk_mega, .walk_fault
    );

endmodule

/* dv/immu_tb.sv */
`timescale 1ns/1ns

module immu_tb
    import immu_pkg::*;
();

    localparam int unsigned TLB_ENTRIES = 4;
    localparam int IDX_W = $clog2(TLB_ENTRIES);
    localparam int N_DIRECTED = 25;
    localparam int N_RANDOM = 200;
    // About 20 cycles covers one request with two slow reads
    localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 20;
    localparam ppn_t ROOT_PPN = 22'h00100;

    // PTE flag nibbles, X W R V
    localparam logic [3:0] F_PTR = 4'b0001;
    localparam logic [3:0] F_RX  = 4'b1011;
    localparam logic [3:0] F_X   = 4'b1001;
    localparam logic [3:0] F_R   = 4'b0011;
    localparam logic [3:0] F_W   = 4'b0101;
    localparam logic [3:0] F_INV = 4'b1110;

    logic   clk;
    logic   rst_n;
    ppn_t   satp_ppn;
    logic   fetch_req;
    vaddr_t fetch_vaddr;
    logic   flush;
    logic   done;
    paddr_t paddr;
    logic   page_fault;
    logic   mem_req;
    paddr_t mem_addr;
    logic   mem_valid = 1'b0;
    pte_t   mem_rdata = '0;

    // Sparse page table memory
    pte_t   mem_model [paddr_t];
    integer seed = 32'h13a1744f;
    paddr_t rd_addr;
    int     rd_wait = 0;

    // Expected response of the pending request
    paddr_t exp_paddr;
    logic   exp_fault;
    int     exp_reads;
    int     issue_cyc;
    int     read_cnt = 0;
    int     req_cnt = 0;
    int     resp_cnt = 0;
    int     cycle_cnt = 0;

    // Shadow of the TLB contents
    logic      sh_valid [TLB_ENTRIES];
    vpn_half_t sh_vpn1  [TLB_ENTRIES];
    vpn_half_t sh_vpn0  [TLB_ENTRIES];
    logic      sh_mega  [TLB_ENTRIES];

    immu_top #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) i_immu_top (
        .clk, .rst_n, .satp_ppn, .fetch_req, .fetch_vaddr, .flush,
        .done, .paddr, .page_fault, .mem_req, .mem_addr, .mem_valid, .mem_rdata
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_paddr(input string name, input paddr_t got, input paddr_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_stop($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_stop($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic pte_t make_pte(input ppn_t ppn, input logic [3:0] flags);
        return {ppn, 6'b000000, flags};
    endfunction

    function automatic vaddr_t make_va(input vpn_half_t vpn1, input vpn_half_t vpn0,
                                       input logic [11:0] off);
        return {vpn1, vpn0, off};
    endfunction

    // Unwritten words read as zero, so they are invalid entries
    function automatic pte_t mem_read(input paddr_t addr);
        if (mem_model.exists(addr)) begin
            return mem_model[addr];
        end
        return '0;
    endfunction

    task automatic set_l1(input vpn_half_t vpn1, input pte_t pte);
        mem_model[{ROOT_PPN, vpn1, 2'b00}] = pte;
    endtask

    task automatic set_l0(input ppn_t table_ppn, input vpn_half_t vpn0, input pte_t pte);
        mem_model[{table_ppn, vpn0, 2'b00}] = pte;
    endtask

    // Sv32 two-level walk over the model memory
    function automatic void ref_translate(input vaddr_t va, output paddr_t pa,
                                          output logic fault, output logic mega,
                                          output int reads);
        pte_t l1;
        pte_t l0;
        l1 = mem_read({ROOT_PPN, va[31:22], 2'b00});
        pa = '0;
        mega = 1'b0;
        reads = 1;
        if (!l1[PTE_V] || (!l1[PTE_R] && l1[PTE_W])) begin
            fault = 1'b1;
        end else if (l1[PTE_R] || l1[PTE_X]) begin
            // Megapage: needs X and ppn0 of zero
            mega = 1'b1;
            fault = !l1[PTE_X] || (l1[19:10] != 10'd0);
            pa = {l1[31:20], va[21:0]};
        end else begin
            reads = 2;
            l0 = mem_read({l1[31:10], va[21:12], 2'b00});
            fault = !l0[PTE_V] || (!l0[PTE_R] && l0[PTE_W]) || !l0[PTE_X];
            pa = {l0[31:10], va[11:0]};
        end
    endfunction

    function automatic logic shadow_hit(input vaddr_t va);
        logic [IDX_W-1:0] idx;
        idx = va[22 +: IDX_W];
        return sh_valid[idx] && (sh_vpn1[idx] == va[31:22]) &&
               ((sh_vpn0[idx] == va[21:12]) || sh_mega[idx]);
    endfunction

    // Negative want_reads takes the count from the shadow TLB
    task automatic run_req(input vaddr_t va, input int want_reads);
        paddr_t pa;
        logic fault;
        logic mega;
        int reads;
        int start_cnt;
        logic [IDX_W-1:0] idx;
        ref_translate(va, pa, fault, mega, reads);
        if (shadow_hit(va)) begin
            reads = 0;
        end
        @(negedge clk);
        exp_paddr = pa;
        exp_fault = fault;
        exp_reads = (want_reads >= 0) ? want_reads : reads;
        issue_cyc = cycle_cnt;
        start_cnt = resp_cnt;
        req_cnt++;
        fetch_req = 1'b1;
        fetch_vaddr = va;
        @(negedge clk);
        fetch_req = 1'b0;
        @(posedge clk);
        while (resp_cnt == start_cnt) begin
            @(posedge clk);
        end
        // Good walks land in the TLB
        if (!fault) begin
            idx = va[22 +: IDX_W];
            sh_valid[idx] = 1'b1;
            sh_vpn1[idx] = va[31:22];
            sh_vpn0[idx] = va[21:12];
            sh_mega[idx] = mega;
        end
    endtask

    task automatic do_flush();
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            sh_valid[i] = 1'b0;
        end
        @(posedge clk);
    endtask

    // Read port with 1 to 4 cycles of latency
    always @(negedge clk) begin
        mem_valid = 1'b0;
        if (rd_wait > 0) begin
            rd_wait--;
            if (rd_wait == 0) begin
                mem_valid = 1'b1;
                mem_rdata = mem_read(rd_addr);
            end
        end
        if (rst_n && mem_req) begin
            rd_addr = mem_addr;
            rd_wait = 1 + int'($unsigned($random(seed)) % 32'd4);
        end
    end

    // Response monitor, compares at each done
    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_req) begin
                read_cnt++;
            end
            if (done && resp_cnt == req_cnt) begin
                fail_stop("done was asserted with no request pending");
            end else if (done) begin
                check_flag("page_fault", page_fault, exp_fault);
                if (!exp_fault) begin
                    check_paddr("paddr", paddr, exp_paddr);
                end
                check_count("mem_req count", read_cnt, exp_reads);
                // Hits answer in the next cycle
                if (exp_reads == 0) begin
                    check_count("done latency", cycle_cnt - issue_cyc, 1);
                end
                read_cnt = 0;
                resp_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_stop($sformatf("timeout after %0d cycles, a done never came", cycle_cnt));
        end
    end

    initial begin
        logic [31:0] rnd;
        rst_n = 1'b0;
        satp_ppn = ROOT_PPN;
        fetch_req = 1'b0;
        fetch_vaddr = '0;
        flush = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            sh_valid[i] = 1'b0;
        end
        // Two pointer tables, megapages and the fault cases
        set_l1(10'd1, make_pte(22'h00200, F_PTR));
        set_l1(10'd2, make_pte({12'hABC, 10'h000}, F_RX));
        set_l1(10'd3, make_pte(22'h12345, F_INV));
        set_l1(10'd4, make_pte(22'h00400, F_W));
        set_l1(10'd5, make_pte(22'h00201, F_PTR));
        set_l1(10'd6, make_pte({12'h0D0, 10'h000}, F_R));
        set_l1(10'd7, make_pte({12'h0E0, 10'h011}, F_X));
        for (int i = 0; i < 4; i++) begin
            set_l0(22'h00200, vpn_half_t'(i), make_pte(ppn_t'(22'h01000 + i), F_RX));
            set_l0(22'h00201, vpn_half_t'(i), make_pte(ppn_t'(22'h02000 + 3 * i), F_X));
        end
        set_l0(22'h00200, 10'd5, make_pte(22'h12345, F_RX));
        set_l0(22'h00200, 10'd6, make_pte(22'h00300, F_PTR));
        set_l0(22'h00200, 10'd7, make_pte(22'h3ABCD, F_X));
        set_l0(22'h00201, 10'd5, make_pte(22'h0BEEF, F_RX));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // 4 KiB miss, then the same address hits
        run_req(make_va(10'd1, 10'd5, 12'h123), 2);
        run_req(make_va(10'd1, 10'd5, 12'h123), 0);
        // Megapage, then a neighbour vpn0 inside it
        run_req(make_va(10'd2, 10'h155, 12'h7ff), 1);
        run_req(make_va(10'd2, 10'h0aa, 12'h004), 0);
        // Each fault twice, never cached
        for (int k = 0; k < 2; k++) begin
            run_req(make_va(10'd3, 10'd0, 12'h010), 1);
            run_req(make_va(10'd4, 10'd0, 12'h020), 1);
            run_req(make_va(10'd6, 10'd1, 12'h030), 1);
            run_req(make_va(10'd7, 10'd2, 12'h040), 1);
            run_req(make_va(10'd1, 10'd6, 12'h050), 2);
        end
        // Flush drops all fills
        run_req(make_va(10'd1, 10'd0, 12'h100), 2);
        run_req(make_va(10'd2, 10'd9, 12'h200), 0);
        do_flush();
        run_req(make_va(10'd1, 10'd0, 12'h100), 2);
        run_req(make_va(10'd2, 10'd9, 12'h200), 1);
        run_req(make_va(10'd1, 10'd0, 12'h104), 0);
        // vpn1 1 and 5 share index 1
        for (int k = 0; k < 3; k++) begin
            run_req(make_va(10'd1, 10'd1, 12'h0f0), 2);
            run_req(make_va(10'd5, 10'd1, 12'h0f4), 2);
        end
        // Mixed random traffic with an occasional flush
        do_flush();
        for (int n = 0; n < N_RANDOM; n++) begin
            rnd = $random(seed);
            if (rnd[23:20] == 4'd0) begin
                do_flush();
            end
            run_req(make_va({7'd0, rnd[2:0]}, {7'd0, rnd[5:3]}, rnd[17:6]), -1);
        end
        if (resp_cnt == req_cnt) begin
            $display("Done: no errors");
            $finish;
        end else begin
            fail_stop("fewer responses than requests at the end of the run");
        end
    end

endmodule

/* filelist.f */
design/immu_pkg.sv
design/itlb.sv
design/page_walker.sv
design/immu_ctrl.sv
design/immu_top.sv
dv/immu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the IMMU testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f filelist.f --top-module immu_tb -o immu_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/immu_sim > sim.log 2>&1
cat sim.log

grep -qx "Done: no errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
